// ==== src/cdc_pkg.sv ====
// ====================
// CDC bridge shared types
// ====================

package cdc_pkg;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  // Widest pointer the conversion functions handle; FIFO pointers are LogDepth+1 bits
  localparam int unsigned PtrMaxWidth = 16;

  // Request beat, 49 bits
  typedef struct packed {
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } req_t;

  // Response beat, 33 bits
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 error;
  } rsp_t;

  function automatic logic [PtrMaxWidth-1:0] bin_to_gray(input logic [PtrMaxWidth-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [PtrMaxWidth-1:0] gray_to_bin(input logic [PtrMaxWidth-1:0] gray);
    logic [PtrMaxWidth-1:0] bin;
    bin = gray;
    // Each binary bit is the XOR of all gray bits at or above it
    for (int i = PtrMaxWidth - 2; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== src/cdc_fifo_wr.sv ====
// ====================
// Async FIFO write half
// ====================

`timescale 1ns/100ps

module cdc_fifo_wr import cdc_pkg::*; #(
  parameter type         T          = logic,
  parameter int unsigned LogDepth   = 2,
  parameter int unsigned SyncStages = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     clear_i,
  input  T                         data_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output T     [2**LogDepth-1:0]   async_data_o,
  output logic [LogDepth:0]        async_wptr_o,
  input  logic [LogDepth:0]        async_rptr_i,
  output logic                     async_clear_o
);

  localparam int unsigned PtrWidth = LogDepth + 1;

  T [2**LogDepth-1:0] mem_q;

  logic [PtrWidth-1:0] wptr_bin_q, wptr_bin_d;
  logic [PtrWidth-1:0] wptr_gray_q, wptr_gray_d;
  logic [PtrWidth-1:0] rptr_gray_s, rptr_bin_s;
  logic [PtrWidth-1:0] count_next;

  // Synchronizer chains, element 0 is the raw input
  logic [SyncStages-1:0][PtrWidth-1:0] rptr_sync_q;
  logic [SyncStages:0][PtrWidth-1:0]   rptr_chain;
  logic [SyncStages-1:0]               clear_sync_q;
  logic [SyncStages:0]                 clear_chain;

  logic clear_q, clear_d;
  logic ready_q, ready_d;
  logic push;

  assign rptr_chain  = {rptr_sync_q, async_rptr_i};
  assign clear_chain = {clear_sync_q, clear_i};
  assign rptr_gray_s = rptr_chain[SyncStages];
  assign clear_q     = clear_chain[SyncStages];
  // Value that clear_q takes on the next edge, so ready can drop in time
  assign clear_d     = clear_chain[SyncStages-1];

  assign push = valid_i & ready_q;

  always_comb begin
    wptr_bin_d = wptr_bin_q;
    if (clear_q) begin
      wptr_bin_d = '0;
    end else if (push) begin
      wptr_bin_d = wptr_bin_q + 1'b1;
    end
  end

  assign wptr_gray_d = PtrWidth'(bin_to_gray(PtrMaxWidth'(wptr_bin_d)));
  assign rptr_bin_s  = PtrWidth'(gray_to_bin(PtrMaxWidth'(rptr_gray_s)));

  // The read pointer only moves forward, so a stale copy keeps the fill level safe
  assign count_next = wptr_bin_d - rptr_bin_s;
  assign ready_d    = ~clear_d & ~count_next[LogDepth];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_bin_q   <= '0;
      wptr_gray_q  <= '0;
      rptr_sync_q  <= '0;
      clear_sync_q <= '0;
      ready_q      <= 1'b0;
    end else begin
      wptr_bin_q   <= wptr_bin_d;
      wptr_gray_q  <= wptr_gray_d;
      rptr_sync_q  <= rptr_chain[SyncStages-1:0];
      clear_sync_q <= clear_chain[SyncStages-1:0];
      ready_q      <= ready_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_bin_q[LogDepth-1:0]] <= data_i;
    end
  end

  assign ready_o       = ready_q;
  assign async_data_o  = mem_q;
  assign async_wptr_o  = wptr_gray_q;
  assign async_clear_o = clear_q;

endmodule

// ==== src/cdc_fifo_rd.sv ====
// ====================
// Async FIFO read half
// ====================

`timescale 1ns/100ps

module cdc_fifo_rd import cdc_pkg::*; #(
  parameter type         T          = logic,
  parameter int unsigned LogDepth   = 2,
  parameter int unsigned SyncStages = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  T     [2**LogDepth-1:0]   async_data_i,
  input  logic [LogDepth:0]        async_wptr_i,
  output logic [LogDepth:0]        async_rptr_o,
  input  logic                     async_clear_i,
  output T                         data_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  localparam int unsigned PtrWidth = LogDepth + 1;

  logic [PtrWidth-1:0] rptr_bin_q, rptr_bin_d;
  logic [PtrWidth-1:0] rptr_gray_q, rptr_gray_d;
  logic [PtrWidth-1:0] wptr_gray_s;

  // Synchronizer chains, element 0 is the raw input from the other domain
  logic [SyncStages-1:0][PtrWidth-1:0] wptr_sync_q;
  logic [SyncStages:0][PtrWidth-1:0]   wptr_chain;
  logic [SyncStages-1:0]               clear_sync_q;
  logic [SyncStages:0]                 clear_chain;

  logic clear_q;
  logic pop;

  assign wptr_chain  = {wptr_sync_q, async_wptr_i};
  assign clear_chain = {clear_sync_q, async_clear_i};
  assign wptr_gray_s = wptr_chain[SyncStages];
  assign clear_q     = clear_chain[SyncStages];

  // Gray pointers compare directly, no conversion needed for the empty test
  assign valid_o = ~clear_q & (rptr_gray_q != wptr_gray_s);
  assign pop     = valid_o & ready_i;

  // Head entry of the shared array
  assign data_o = async_data_i[rptr_bin_q[LogDepth-1:0]];

  always_comb begin
    rptr_bin_d = rptr_bin_q;
    if (clear_q) begin
      // Stale entries vanish once the write side has also returned to zero
      rptr_bin_d = '0;
    end else if (pop) begin
      rptr_bin_d = rptr_bin_q + 1'b1;
    end
  end

  assign rptr_gray_d = PtrWidth'(bin_to_gray(PtrMaxWidth'(rptr_bin_d)));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rptr_bin_q   <= '0;
      rptr_gray_q  <= '0;
      wptr_sync_q  <= '0;
      clear_sync_q <= '0;
    end else begin
      rptr_bin_q   <= rptr_bin_d;
      rptr_gray_q  <= rptr_gray_d;
      wptr_sync_q  <= wptr_chain[SyncStages-1:0];
      clear_sync_q <= clear_chain[SyncStages-1:0];
    end
  end

  // Registered gray value, so only one bit changes per update
  assign async_rptr_o = rptr_gray_q;

endmodule

// ==== src/clear_seq_fsm.sv ====
// ====================
// Clear sequencer
// ====================

`timescale 1ns/100ps

module clear_seq_fsm (
  input  logic clk_i,
  input  logic rst_i,
  input  logic clear_req_i,
  output logic timer_start_o,
  input  logic timer_done_i,
  output logic fifo_clear_o,
  output logic busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    HOLD,
    SETTLE
  } state_e;

  state_e state_q, state_d;

  // The timer is reloaded on entry to both HOLD and SETTLE
  always_comb begin
    state_d       = state_q;
    timer_start_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (clear_req_i) begin
          state_d       = HOLD;
          timer_start_o = 1'b1;
        end
      end
      HOLD: begin
        if (timer_done_i) begin
          state_d       = SETTLE;
          timer_start_o = 1'b1;
        end
      end
      SETTLE: begin
        // Requests seen here are dropped, the sequence is already running
        if (timer_done_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // FIFO clear is only held during HOLD; SETTLE lets the synchronizers drain
  assign fifo_clear_o = (state_q == HOLD);
  assign busy_o       = (state_q != IDLE);

endmodule

// ==== src/clear_timer.sv ====
// ====================
// Clear interval timer
// ====================

`timescale 1ns/100ps

module clear_timer #(
  parameter int unsigned ClearCycles = 6
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic start_i,
  output logic done_o
);

  localparam int unsigned CntWidth = $clog2(ClearCycles + 1);

  logic [CntWidth-1:0] count_q;
  logic                running_q;

  // A start while the last interval is ending reloads without a gap
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (start_i) begin
      count_q   <= CntWidth'(ClearCycles - 1);
      running_q <= 1'b1;
    end else if (running_q) begin
      if (count_q == '0) begin
        running_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign done_o = running_q & (count_q == '0);

endmodule

// ==== src/cdc_bridge_top.sv ====
// ====================
// Clearable CDC bridge
// ====================

`timescale 1ns/100ps

module cdc_bridge_top import cdc_pkg::*; #(
  parameter int unsigned LogDepth    = 2,
  parameter int unsigned SyncStages  = 2,
  parameter int unsigned ClearCycles = 2 * SyncStages + 2
) (
  input  logic src_clk_i,
  input  logic dst_clk_i,
  input  logic rst_i,
  // Source side, clocked by src_clk_i
  input  req_t src_req_data_i,
  input  logic src_req_valid_i,
  output logic src_req_ready_o,
  output rsp_t src_rsp_data_o,
  output logic src_rsp_valid_o,
  input  logic src_rsp_ready_i,
  input  logic src_clear_i,
  output logic src_clear_busy_o,
  // Destination side, clocked by dst_clk_i
  output req_t dst_req_data_o,
  output logic dst_req_valid_o,
  input  logic dst_req_ready_i,
  input  rsp_t dst_rsp_data_i,
  input  logic dst_rsp_valid_i,
  output logic dst_rsp_ready_o
);

  localparam int unsigned Depth = 2 ** LogDepth;

  req_t [Depth-1:0]  req_async_data;
  logic [LogDepth:0] req_async_wptr;
  logic [LogDepth:0] req_async_rptr;
  logic              req_async_clear;

  rsp_t [Depth-1:0]  rsp_async_data;
  logic [LogDepth:0] rsp_async_wptr;
  logic [LogDepth:0] rsp_async_rptr;

  logic timer_start, timer_done;
  logic fifo_clear, clear_busy;
  logic src_req_ready, src_rsp_valid;

  // Source ports are isolated for the whole clear sequence
  assign src_req_ready_o  = src_req_ready & ~clear_busy;
  assign src_rsp_valid_o  = src_rsp_valid & ~clear_busy;
  assign src_clear_busy_o = clear_busy;

  cdc_fifo_wr #(
    .T          ( req_t      ),
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages )
  ) i_req_wr (
    .clk_i         ( src_clk_i                      ),
    .rst_i,
    .clear_i       ( fifo_clear                     ),
    .data_i        ( src_req_data_i                 ),
    .valid_i       ( src_req_valid_i & ~clear_busy  ),
    .ready_o       ( src_req_ready                  ),
    .async_data_o  ( req_async_data                 ),
    .async_wptr_o  ( req_async_wptr                 ),
    .async_rptr_i  ( req_async_rptr                 ),
    .async_clear_o ( req_async_clear                )
  );

  cdc_fifo_rd #(
    .T          ( req_t      ),
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages )
  ) i_req_rd (
    .clk_i         ( dst_clk_i       ),
    .rst_i,
    .async_data_i  ( req_async_data  ),
    .async_wptr_i  ( req_async_wptr  ),
    .async_rptr_o  ( req_async_rptr  ),
    .async_clear_i ( req_async_clear ),
    .data_o        ( dst_req_data_o  ),
    .valid_o       ( dst_req_valid_o ),
    .ready_i       ( dst_req_ready_i )
  );

  // Destination-side write half learns of the clear through the request clear level
  cdc_fifo_wr #(
    .T          ( rsp_t      ),
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages )
  ) i_rsp_wr (
    .clk_i         ( dst_clk_i       ),
    .rst_i,
    .clear_i       ( req_async_clear ),
    .data_i        ( dst_rsp_data_i  ),
    .valid_i       ( dst_rsp_valid_i ),
    .ready_o       ( dst_rsp_ready_o ),
    .async_data_o  ( rsp_async_data  ),
    .async_wptr_o  ( rsp_async_wptr  ),
    .async_rptr_i  ( rsp_async_rptr  ),
    .async_clear_o (                 )
  );

  // The response read half shares the source domain, so it takes the clear directly
  cdc_fifo_rd #(
    .T          ( rsp_t      ),
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages )
  ) i_rsp_rd (
    .clk_i         ( src_clk_i                      ),
    .rst_i,
    .async_data_i  ( rsp_async_data                 ),
    .async_wptr_i  ( rsp_async_wptr                 ),
    .async_rptr_o  ( rsp_async_rptr                 ),
    .async_clear_i ( fifo_clear                     ),
    .data_o        ( src_rsp_data_o                 ),
    .valid_o       ( src_rsp_valid                  ),
    .ready_i       ( src_rsp_ready_i & ~clear_busy  )
  );

  clear_seq_fsm i_clear_seq (
    .clk_i         ( src_clk_i   ),
    .rst_i,
    .clear_req_i   ( src_clear_i ),
    .timer_start_o ( timer_start ),
    .timer_done_i  ( timer_done  ),
    .fifo_clear_o  ( fifo_clear  ),
    .busy_o        ( clear_busy  )
  );

  clear_timer #(
    .ClearCycles ( ClearCycles )
  ) i_clear_timer (
    .clk_i   ( src_clk_i   ),
    .rst_i,
    .start_i ( timer_start ),
    .done_o  ( timer_done  )
  );

endmodule

// ==== tests/cdc_bridge_chk.sv ====
// ====================
// CDC bridge assertions
// ====================

`timescale 1ns/100ps

module cdc_bridge_chk #(
  parameter int unsigned ClearCycles = 6
) (
  input logic src_clk_i,
  input logic dst_clk_i,
  input logic rst_i,
  input logic clear_req_i,
  input logic busy_i,
  input logic fifo_clear_i,
  input logic src_req_ready_i,
  input logic src_rsp_valid_i,
  input logic dst_req_valid_i,
  input logic dst_rsp_ready_i
);

  int unsigned fail_cnt = 0;
  int unsigned busy_run_q;

  // Number of source cycles busy has been high so far
  always_ff @(posedge src_clk_i) begin
    if (rst_i || !busy_i) begin
      busy_run_q <= 0;
    end else begin
      busy_run_q <= busy_run_q + 1;
    end
  end

  clear_starts: assert property (@(posedge src_clk_i) disable iff (rst_i)
      clear_req_i && !busy_i |=> busy_i)
    else begin
      fail_cnt++;
      $error("Clear request seen while idle did not raise busy");
    end

  busy_length: assert property (@(posedge src_clk_i) disable iff (rst_i)
      $fell(busy_i) |-> busy_run_q == 2 * ClearCycles)
    else begin
      fail_cnt++;
      $error("FAILED at %0t: src_clear_busy_o high for %0d cycles, expected %0d",
             $time, $sampled(busy_run_q), 2 * ClearCycles);
    end

  // FIFO clear covers the first half of busy and nothing else
  clear_in_hold: assert property (@(posedge src_clk_i) disable iff (rst_i)
      fifo_clear_i == (busy_i && busy_run_q < ClearCycles))
    else begin
      fail_cnt++;
      $error("FIFO clear does not match the hold interval");
    end

  ports_isolated: assert property (@(posedge src_clk_i) disable iff (rst_i)
      busy_i |-> !src_req_ready_i && !src_rsp_valid_i)
    else begin
      fail_cnt++;
      $error("Source request ready or response valid is high during busy");
    end

  src_reset_low: assert property (@(posedge src_clk_i)
      rst_i |=> !busy_i && !src_req_ready_i && !src_rsp_valid_i)
    else begin
      fail_cnt++;
      $error("Source control output is high right after reset");
    end

  dst_reset_low: assert property (@(posedge dst_clk_i)
      rst_i |=> !dst_req_valid_i && !dst_rsp_ready_i)
    else begin
      fail_cnt++;
      $error("Destination control output is high right after reset");
    end

endmodule

// ==== tests/cdc_bridge_tb.sv ====
// ====================
// CDC bridge testbench
// ====================

`timescale 1ns/100ps

module cdc_bridge_tb import cdc_pkg::*; ();

  localparam int unsigned LogDepth    = 2;
  localparam int unsigned SyncStages  = 2;
  localparam int unsigned ClearCycles = 2 * SyncStages + 2;
  localparam int unsigned Depth       = 2 ** LogDepth;
  localparam int unsigned Timeout     = 200;

  logic src_clk = 1'b0;
  logic dst_clk = 1'b0;
  logic rst;
  logic src_req_valid, src_req_ready, src_rsp_valid, src_rsp_ready;
  logic dst_req_valid, dst_req_ready, dst_rsp_valid, dst_rsp_ready;
  logic src_clear, src_clear_busy;
  req_t src_req_data, dst_req_data;
  rsp_t src_rsp_data, dst_rsp_data;

  // Both sink readies are low in mode 0, high in mode 1 and random in mode 2
  logic [1:0]  sink_mode = 2'd2;
  logic [31:0] lfsr      = 32'hf561803a;
  int unsigned errors    = 0;
  int unsigned req_count = 0;
  int unsigned rsp_count = 0;
  req_t        req_q[$];
  rsp_t        rsp_q[$];

  cdc_bridge_top #(
    .LogDepth    ( LogDepth    ),
    .SyncStages  ( SyncStages  ),
    .ClearCycles ( ClearCycles )
  ) cdc_bridge_top_i (
    .src_clk_i        ( src_clk        ),
    .dst_clk_i        ( dst_clk        ),
    .rst_i            ( rst            ),
    .src_req_data_i   ( src_req_data   ),
    .src_req_valid_i  ( src_req_valid  ),
    .src_req_ready_o  ( src_req_ready  ),
    .src_rsp_data_o   ( src_rsp_data   ),
    .src_rsp_valid_o  ( src_rsp_valid  ),
    .src_rsp_ready_i  ( src_rsp_ready  ),
    .src_clear_i      ( src_clear      ),
    .src_clear_busy_o ( src_clear_busy ),
    .dst_req_data_o   ( dst_req_data   ),
    .dst_req_valid_o  ( dst_req_valid  ),
    .dst_req_ready_i  ( dst_req_ready  ),
    .dst_rsp_data_i   ( dst_rsp_data   ),
    .dst_rsp_valid_i  ( dst_rsp_valid  ),
    .dst_rsp_ready_o  ( dst_rsp_ready  )
  );

  bind cdc_bridge_top cdc_bridge_chk #(
    .ClearCycles ( ClearCycles )
  ) i_chk (
    .src_clk_i       ( src_clk_i        ),
    .dst_clk_i       ( dst_clk_i        ),
    .rst_i           ( rst_i            ),
    .clear_req_i     ( src_clear_i      ),
    .busy_i          ( src_clear_busy_o ),
    .fifo_clear_i    ( fifo_clear       ),
    .src_req_ready_i ( src_req_ready_o  ),
    .src_rsp_valid_i ( src_rsp_valid_o  ),
    .dst_req_valid_i ( dst_req_valid_o  ),
    .dst_rsp_ready_i ( dst_rsp_ready_o  )
  );

  always #20 src_clk = ~src_clk;

  // Destination clock runs 13 ns behind the source clock
  always begin
    #13;
    forever #20 dst_clk = ~dst_clk;
  end

  // Galois LFSR stepped once for every bit taken
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic timed_out(input string what);
    errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic check_req(input req_t got);
    req_t exp;
    if (req_q.size() == 0) begin
      errors++;
      $display("Request arrived at %0t with no request outstanding", $time);
    end else begin
      exp = req_q.pop_front();
      assert (got == exp) else begin
        errors++;
        $display("FAILED at %0t: dst_req_data_o expected %h got %h", $time, exp, got);
      end
    end
  endtask

  task automatic check_rsp(input rsp_t got);
    rsp_t exp;
    if (rsp_q.size() == 0) begin
      errors++;
      $display("Response arrived at %0t with no response outstanding", $time);
    end else begin
      exp = rsp_q.pop_front();
      assert (got == exp) else begin
        errors++;
        $display("FAILED at %0t: src_rsp_data_o expected %h got %h", $time, exp, got);
      end
    end
  endtask

  task automatic send_req(input int unsigned n);
    logic [63:0] bits;
    int unsigned waited;
    repeat (n) begin
      @(negedge src_clk);
      bits          = rand_bits($bits(req_t));
      src_req_data  = bits[$bits(req_t)-1:0];
      src_req_valid = 1'b1;
      waited        = 0;
      do begin
        @(posedge src_clk);
        waited++;
      end while (!src_req_ready && waited < Timeout);
      if (!src_req_ready) begin
        timed_out("src_req_ready_o");
      end
    end
    @(negedge src_clk);
    src_req_valid = 1'b0;
  endtask

  task automatic send_rsp(input int unsigned n);
    logic [63:0] bits;
    int unsigned waited;
    repeat (n) begin
      @(negedge dst_clk);
      bits          = rand_bits($bits(rsp_t));
      dst_rsp_data  = bits[$bits(rsp_t)-1:0];
      dst_rsp_valid = 1'b1;
      waited        = 0;
      do begin
        @(posedge dst_clk);
        waited++;
      end while (!dst_rsp_ready && waited < Timeout);
      if (!dst_rsp_ready) begin
        timed_out("dst_rsp_ready_o");
      end
    end
    @(negedge dst_clk);
    dst_rsp_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while ((req_q.size() != 0 || rsp_q.size() != 0) && waited < Timeout) begin
      @(negedge src_clk);
      waited++;
    end
    if (req_q.size() != 0 || rsp_q.size() != 0) begin
      timed_out("both directions to drain");
    end
  endtask

  task automatic wait_busy(input logic level);
    int unsigned waited;
    waited = 0;
    while (src_clear_busy !== level && waited < Timeout) begin
      @(negedge src_clk);
      waited++;
    end
    if (src_clear_busy !== level) begin
      timed_out("src_clear_busy_o");
    end
  endtask

  always @(negedge dst_clk) begin
    dst_req_ready = (sink_mode == 2'd2) ? (rand_bits(1) != 0) : sink_mode[0];
  end

  always @(negedge src_clk) begin
    src_rsp_ready = (sink_mode == 2'd2) ? (rand_bits(1) != 0) : sink_mode[0];
  end

  // Handshakes are taken on the rising edge where valid and ready are both high
  always @(posedge src_clk) begin
    if (!rst && src_req_valid && src_req_ready) begin
      req_q.push_back(src_req_data);
      req_count++;
    end
    if (!rst && src_rsp_valid && src_rsp_ready) begin
      check_rsp(src_rsp_data);
    end
  end

  always @(posedge dst_clk) begin
    if (!rst && dst_req_valid && dst_req_ready) begin
      check_req(dst_req_data);
    end
    if (!rst && dst_rsp_valid && dst_rsp_ready) begin
      rsp_q.push_back(dst_rsp_data);
      rsp_count++;
    end
  end

  initial begin
    int unsigned base;
    int unsigned waited;
    rst           = 1'b1;
    src_req_data  = '0;
    src_req_valid = 1'b0;
    src_rsp_ready = 1'b0;
    src_clear     = 1'b0;
    dst_req_ready = 1'b0;
    dst_rsp_data  = '0;
    dst_rsp_valid = 1'b0;
    repeat (8) @(posedge src_clk);
    @(negedge src_clk);
    rst = 1'b0;

    // Both directions stream under random back-pressure
    fork
      send_req(20);
      send_rsp(20);
    join
    wait_drained();

    // The request FIFO fills up while the destination is stalled
    sink_mode = 2'd0;
    base      = req_count;
    fork
      send_req(Depth + 2);
      begin
        waited = 0;
        while (req_count < base + Depth && waited < Timeout) begin
          @(negedge src_clk);
          waited++;
        end
        if (req_count < base + Depth) begin
          timed_out("the request FIFO to fill");
        end
        repeat (8) begin
          @(negedge src_clk);
          assert (!src_req_ready) else begin
            errors++;
            $display("FAILED at %0t: src_req_ready_o expected 0 got %b", $time, src_req_ready);
          end
          assert (req_count == base + Depth) else begin
            errors++;
            $display("FAILED at %0t: src_req_ready_o handshakes expected %0d got %0d",
                     $time, Depth, req_count - base);
          end
        end
        sink_mode = 2'd1;
      end
    join
    wait_drained();

    // Both FIFOs hold data when the clear starts
    sink_mode = 2'd0;
    fork
      send_req(Depth - 1);
      send_rsp(Depth - 1);
    join
    @(negedge src_clk);
    src_clear = 1'b1;
    @(negedge src_clk);
    src_clear = 1'b0;
    wait_busy(1'b1);
    // These requests fall into the hold and settle intervals and are ignored
    @(negedge src_clk);
    src_clear = 1'b1;
    @(negedge src_clk);
    src_clear = 1'b0;
    repeat (ClearCycles) @(negedge src_clk);
    src_clear = 1'b1;
    @(negedge src_clk);
    src_clear = 1'b0;
    wait_busy(1'b0);
    req_q.delete();
    rsp_q.delete();
    sink_mode = 2'd2;
    fork
      send_req(8);
      send_rsp(8);
    join
    wait_drained();

    $display("Run complete: %0d requests, %0d responses, %0d testbench errors, %0d assertion errors",
             req_count, rsp_count, errors, cdc_bridge_top_i.i_chk.fail_cnt);
    if (errors == 0 && cdc_bridge_top_i.i_chk.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #400_000;
    $display("Simulation did not finish within the time limit");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== all.f ====
src/cdc_pkg.sv
src/cdc_fifo_wr.sv
src/cdc_fifo_rd.sv
src/clear_seq_fsm.sv
src/clear_timer.sv
src/cdc_bridge_top.sv
tests/cdc_bridge_chk.sv
tests/cdc_bridge_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the CDC bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module cdc_bridge_tb -f all.f -o sim_cdc_bridge
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let failing assertions keep running so the testbench can report them
out=$(./obj_dir/sim_cdc_bridge +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
